/* hw/spiPkg.sv */
package spiPkg;

	// Peripheral bus request from the host
	typedef struct packed {
		logic enable;
		logic we;
		logic oe;
		logic [15:0] address;
		logic [31:0] writeData;
	} busRequest_t;

	// Configuration register layout, high bit first
	typedef struct packed {
		logic activeHighCS;
		logic useCS;
		logic msbFirst;
		logic [1:0] spiMode;
		logic [2:0] clockScale;
	} spiConfig_t;

	typedef struct packed {
		logic en;
		logic sclk;
		logic mosi;
		logic cs;
	} spiPins_t;

	// Scale 4, mode 0, MSB first, active low chip select
	localparam logic [7:0] CONFIG_DEFAULT = 8'h64;

	localparam logic [11:0] CONFIG_ADDRESS = 12'h000;
	localparam logic [11:0] DATA_ADDRESS = 12'h004;

endpackage

/* hw/peripheralRegister.sv */
module peripheralRegister import spiPkg::*; #(
	parameter type payload_t = logic [7:0],
	parameter logic [11:0] ADDRESS = 12'h000,
	parameter payload_t DEFAULT = payload_t'(0)
) (
	input logic clk,
	input logic rst,
	input logic selected,
	input busRequest_t request,
	output payload_t value,
	output logic written
);

	logic hit;

	// Only the local part of the address is decoded here
	assign hit = selected && request.we && (request.address[11:0] == ADDRESS);

	always_ff @(posedge clk) begin
		if (rst) begin
			value <= DEFAULT;
		end else if (hit) begin
			value <= payload_t'(request.writeData[$bits(payload_t)-1:0]);
		end
	end

	// Pulses on the edge that captures the new value
	always_ff @(posedge clk) begin
		if (rst) begin
			written <= 1'b0;
		end else begin
			written <= hit;
		end
	end

endmodule

/* hw/busInterface.sv */
module busInterface import spiPkg::*; #(
	parameter logic [3:0] ID = 4'h0,
	parameter int WIDTH = 8
) (
	input logic clk,
	input logic rst,
	input busRequest_t request,
	input logic transferBusy,
	input logic [WIDTH-1:0] rxWord,
	output logic [31:0] readData,
	output spiConfig_t spiConfig,
	output logic [WIDTH-1:0] txWord,
	output logic start
);

	logic selected;
	logic [11:0] localAddress;
	logic dataWritten;

	// Top nibble picks the peripheral
	assign selected = request.enable && (request.address[15:12] == ID);
	assign localAddress = request.address[11:0];

	peripheralRegister #(
		.payload_t(spiConfig_t),
		.ADDRESS(CONFIG_ADDRESS),
		.DEFAULT(spiConfig_t'(CONFIG_DEFAULT))
	) configRegister (
		.clk(clk),
		.rst(rst),
		.selected(selected),
		.request(request),
		.value(spiConfig),
		.written()
	);

	peripheralRegister #(
		.payload_t(logic [WIDTH-1:0]),
		.ADDRESS(DATA_ADDRESS),
		.DEFAULT('0)
	) dataRegister (
		.clk(clk),
		.rst(rst),
		.selected(selected),
		.request(request),
		.value(txWord),
		.written(dataWritten)
	);

	// Writes during a transfer are dropped
	assign start = dataWritten && !transferBusy;

	always_comb begin
		readData = '0;
		if (selected && request.oe) begin
			case (localAddress)
				CONFIG_ADDRESS: readData = 32'(spiConfig);
				DATA_ADDRESS: readData = 32'(rxWord);
				default: readData = '0;
			endcase
		end
	end

endmodule

/* hw/shiftRegister.sv */
module shiftRegister #(
	parameter int WIDTH = 8
) (
	input logic clk,
	input logic rst,
	input logic load,
	input logic sampleStrobe,
	input logic shiftStrobe,
	input logic msbFirst,
	input logic [WIDTH-1:0] parallelIn,
	output logic [WIDTH-1:0] parallelOut,
	input logic miso,
	output logic mosi
);

	logic [WIDTH-1:0] data;
	logic heldBit;

	always_ff @(posedge clk) begin
		if (rst) begin
			data <= '0;
			heldBit <= 1'b0;
		end else if (load) begin
			data <= parallelIn;
		end else begin
			if (sampleStrobe) begin
				heldBit <= miso;
			end
			// Held bit enters at the end opposite the output
			if (shiftStrobe) begin
				if (msbFirst) begin
					data <= {data[WIDTH-2:0], heldBit};
				end else begin
					data <= {heldBit, data[WIDTH-1:1]};
				end
			end
		end
	end

	assign mosi = msbFirst ? data[WIDTH-1] : data[0];
	assign parallelOut = data;

endmodule

/* hw/spiController.sv */
module spiController import spiPkg::*; #(
	parameter int WIDTH = 8,
	parameter int CLOCK_WIDTH = 8
) (
	input logic clk,
	input logic rst,
	input spiConfig_t spiConfig,
	input logic start,
	input logic mosi,
	output logic load,
	output logic sampleStrobe,
	output logic shiftStrobe,
	output spiPins_t spi,
	output logic transferBusy
);

	localparam int BIT_BITS = $clog2(WIDTH);

	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		SHIFT,
		FINISH
	} state_t;

	state_t state;
	spiConfig_t latched;
	logic [CLOCK_WIDTH-1:0] clockCounter;
	logic [BIT_BITS-1:0] bitCounter;
	logic [CLOCK_WIDTH-1:0] halfPeriod;
	logic [CLOCK_WIDTH-1:0] fullPeriod;
	logic halfDone;
	logic periodDone;
	logic leadingEdge;
	logic trailingEdge;
	logic finalShift;
	logic polarity;
	logic phase;

	assign polarity = latched.spiMode[1];
	assign phase = latched.spiMode[0];

	// Half period is 2^clockScale system clocks
	assign halfPeriod = CLOCK_WIDTH'(1) << latched.clockScale;
	assign fullPeriod = halfPeriod << 1;
	assign halfDone = clockCounter == halfPeriod - 1'b1;
	assign periodDone = clockCounter == fullPeriod - 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			latched <= spiConfig_t'(CONFIG_DEFAULT);
			clockCounter <= '0;
			bitCounter <= '0;
			load <= 1'b0;
		end else begin
			load <= 1'b0;
			case (state)
				IDLE: begin
					clockCounter <= '0;
					bitCounter <= '0;
					if (start) begin
						latched <= spiConfig;
						load <= 1'b1;
						state <= SETUP;
					end
				end
				SETUP: begin
					if (halfDone) begin
						clockCounter <= '0;
						state <= SHIFT;
					end else begin
						clockCounter <= clockCounter + 1'b1;
					end
				end
				SHIFT: begin
					if (periodDone) begin
						clockCounter <= '0;
						if (bitCounter == BIT_BITS'(WIDTH - 1)) begin
							state <= FINISH;
						end else begin
							bitCounter <= bitCounter + 1'b1;
						end
					end else begin
						clockCounter <= clockCounter + 1'b1;
					end
				end
				FINISH: begin
					if (halfDone) begin
						clockCounter <= '0;
						state <= IDLE;
					end else begin
						clockCounter <= clockCounter + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign transferBusy = state != IDLE;

	// Edges of sclk as seen in the cycle it changes
	assign leadingEdge = (state == SHIFT) && (clockCounter == '0);
	assign trailingEdge = (state == SHIFT) && (clockCounter == halfPeriod);

	// Phase 1 has no shift on the first leading edge since the first bit is
	// already out after load, so the last sample is shifted in at the start of FINISH
	assign finalShift = phase && (state == FINISH) && (clockCounter == '0);

	always_comb begin
		if (phase) begin
			sampleStrobe = trailingEdge;
			shiftStrobe = (leadingEdge && bitCounter != '0) || finalShift;
		end else begin
			sampleStrobe = leadingEdge;
			shiftStrobe = trailingEdge;
		end
	end

	assign spi.en = transferBusy;
	assign spi.sclk = polarity ^ ((state == SHIFT) && (clockCounter < halfPeriod));
	assign spi.mosi = mosi;
	assign spi.cs = latched.useCS ? (latched.activeHighCS ~^ transferBusy) : 1'b0;

endmodule

/* hw/spiDevice.sv */
module spiDevice import spiPkg::*; #(
	parameter logic [3:0] ID = 4'h0,
	parameter int WIDTH = 8
) (
	input logic clk,
	input logic rst,
	input busRequest_t request,
	output logic [31:0] readData,
	output logic busy,
	output spiPins_t spi,
	input logic miso
);

	spiConfig_t spiConfig;
	logic [WIDTH-1:0] txWord;
	logic [WIDTH-1:0] rxWord;
	logic start;
	logic load;
	logic sampleStrobe;
	logic shiftStrobe;
	logic mosi;

	busInterface #(.ID(ID), .WIDTH(WIDTH)) bus0 (
		.clk(clk),
		.rst(rst),
		.request(request),
		.transferBusy(busy),
		.rxWord(rxWord),
		.readData(readData),
		.spiConfig(spiConfig),
		.txWord(txWord),
		.start(start)
	);

	spiController #(.WIDTH(WIDTH)) controller0 (
		.clk(clk),
		.rst(rst),
		.spiConfig(spiConfig),
		.start(start),
		.mosi(mosi),
		.load(load),
		.sampleStrobe(sampleStrobe),
		.shiftStrobe(shiftStrobe),
		.spi(spi),
		.transferBusy(busy)
	);

	shiftRegister #(.WIDTH(WIDTH)) shifter0 (
		.clk(clk),
		.rst(rst),
		.load(load),
		.sampleStrobe(sampleStrobe),
		.shiftStrobe(shiftStrobe),
		.msbFirst(spiConfig.msbFirst),
		.parallelIn(txWord),
		.parallelOut(rxWord),
		.miso(miso),
		.mosi(mosi)
	);

endmodule

/* test/spiDevice_sva.sv */
module spiControllerAssertions import spiPkg::*; (
	input logic clk,
	input logic rst,
	input logic start,
	input logic transferBusy,
	input spiPins_t spi,
	input spiConfig_t latched
);

	// Idle cs level of the latched configuration
	csIdle: assert property (@(posedge clk) disable iff (rst)
		!transferBusy |-> spi.cs == (latched.useCS && !latched.activeHighCS))
		else $error("cs left its idle level outside a transfer");

	sclkIdle: assert property (@(posedge clk) disable iff (rst)
		!transferBusy |-> spi.sclk == latched.spiMode[1])
		else $error("sclk is not at the clock polarity while idle");

	noStartWhenBusy: assert property (@(posedge clk) disable iff (rst)
		transferBusy |-> !start)
		else $error("start issued during a running transfer");

endmodule

bind spiController spiControllerAssertions assertions0 (
	.clk(clk),
	.rst(rst),
	.start(start),
	.transferBusy(transferBusy),
	.spi(spi),
	.latched(latched)
);

/* test/spiDeviceTb.sv */
module spiDeviceTb import spiPkg::*; ();

	localparam int WIDTH = 8;
	localparam logic [3:0] DUT_ID = 4'h3;
	localparam int BUSY_TIMEOUT = 5000;
	localparam int NUM_ROWS = 9;

	typedef enum logic [1:0] {
		CONFIG_ROW,
		TRANSFER_ROW,
		DROP_ROW
	} rowKind_t;

	typedef struct packed {
		rowKind_t kind;
		spiConfig_t cfg;
		logic [WIDTH-1:0] data;
		logic [3:0] id;
		logic [31:0] expected;
	} testRow_t;

	logic clk;
	logic rst;
	busRequest_t request;
	logic [31:0] readData;
	logic busy;
	spiPins_t spi;
	logic miso;

	testRow_t rows[NUM_ROWS];
	string names[NUM_ROWS];
	logic [31:0] lcgState;
	int testErrors;
	int passedTests;
	int failedTests;
	logic sampledBits[$];
	logic monitorPol;
	logic monitorPhase;
	logic prevSclk;
	logic prevEn;

	spiDevice #(.ID(DUT_ID), .WIDTH(WIDTH)) dut0 (
		.clk(clk),
		.rst(rst),
		.request(request),
		.readData(readData),
		.busy(busy),
		.spi(spi),
		.miso(miso)
	);

	// Loopback slave
	assign miso = spi.mosi;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Record mosi on the sampling edge of sclk for the current mode
	always @(posedge clk) begin
		if (spi.en && prevEn && spi.sclk != prevSclk &&
				((spi.sclk ^ monitorPol) != monitorPhase)) begin
			sampledBits.push_back(spi.mosi);
		end
		prevSclk = spi.sclk;
		prevEn = spi.en;
	end

	function automatic logic [WIDTH-1:0] nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[23:16];
	endfunction

	function automatic logic [WIDTH-1:0] wordFromBits(input logic msbFirst);
		logic [WIDTH-1:0] w;
		w = '0;
		foreach (sampledBits[i]) begin
			if (msbFirst) begin
				w = {w[WIDTH-2:0], sampledBits[i]};
			end else begin
				w = {sampledBits[i], w[WIDTH-1:1]};
			end
		end
		return w;
	endfunction

	function automatic spiPins_t expectedPins(input spiConfig_t c, input logic [WIDTH-1:0] d,
			input logic active);
		spiPins_t p;
		p.en = active;
		p.sclk = c.spiMode[1];
		p.mosi = c.msbFirst ? d[WIDTH-1] : d[0];
		// Active level of cs follows activeHighCS
		if (!c.useCS) begin
			p.cs = 1'b0;
		end else begin
			p.cs = active ? c.activeHighCS : !c.activeHighCS;
		end
		return p;
	endfunction

	task automatic checkConfig(input string name, input spiConfig_t expected,
			input spiConfig_t actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			testErrors++;
		end
	endtask

	task automatic checkWord(input string name, input logic [WIDTH-1:0] expected,
			input logic [WIDTH-1:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			testErrors++;
		end
	endtask

	task automatic checkPins(input string name, input spiPins_t expected, input spiPins_t actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %b, actual %b", name, expected, actual);
			testErrors++;
		end
	endtask

	task automatic busWrite(input logic [3:0] id, input logic [11:0] addr, input logic [31:0] value);
		@(posedge clk);
		#2;
		request = {1'b1, 1'b1, 1'b0, id, addr, value};
		@(posedge clk);
		#2;
		request = '0;
	endtask

	task automatic busRead(input logic [3:0] id, input logic [11:0] addr, output logic [31:0] value);
		@(posedge clk);
		#2;
		request = {1'b1, 1'b0, 1'b1, id, addr, 32'h0};
		#10;
		value = readData;
		@(posedge clk);
		#2;
		request = '0;
	endtask

	task automatic waitBusy(input string name, input logic level, output logic ok);
		int cycles;
		cycles = 0;
		while (busy !== level && cycles < BUSY_TIMEOUT) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		ok = (busy === level);
		if (!ok) begin
			$display("%s: busy did not go to %0d within %0d cycles", name, level, BUSY_TIMEOUT);
			testErrors++;
		end
	endtask

	task automatic setRow(input int i, input string name, input rowKind_t kind, input logic [7:0] cfg,
			input logic [WIDTH-1:0] data, input logic [3:0] id, input logic [31:0] expected);
		names[i] = name;
		rows[i] = {kind, spiConfig_t'(cfg), data, id, expected};
	endtask

	task automatic buildTable();
		logic [WIDTH-1:0] randomByte;
		setRow(0, "cfgWrite", CONFIG_ROW, 8'hA5, 8'h00, DUT_ID, 32'h0000_00A5);
		setRow(1, "cfgOtherId", CONFIG_ROW, 8'h1B, 8'h00, 4'h5, 32'h0000_00A5);
		setRow(2, "mode0", TRANSFER_ROW, 8'h61, 8'h96, DUT_ID, 32'h0000_0096);
		setRow(3, "mode1Lsb", TRANSFER_ROW, 8'h4A, 8'h3C, DUT_ID, 32'h0000_003C);
		setRow(4, "mode2CsHigh", TRANSFER_ROW, 8'hF1, 8'hA7, DUT_ID, 32'h0000_00A7);
		setRow(5, "mode3NoCs", TRANSFER_ROW, 8'h3B, 8'h5E, DUT_ID, 32'h0000_005E);
		randomByte = nextRandom();
		setRow(6, "randomA", TRANSFER_ROW, 8'hD9, randomByte, DUT_ID, 32'(randomByte));
		randomByte = nextRandom();
		setRow(7, "randomB", TRANSFER_ROW, 8'h22, randomByte, DUT_ID, 32'(randomByte));
		setRow(8, "dropSecond", DROP_ROW, 8'h62, 8'hC3, DUT_ID, 32'h0000_00C3);
	endtask

	task automatic runConfig(input int i);
		logic [31:0] value;
		busWrite(rows[i].id, CONFIG_ADDRESS, 32'(rows[i].cfg));
		busRead(DUT_ID, CONFIG_ADDRESS, value);
		checkConfig(names[i], spiConfig_t'(rows[i].expected[7:0]), spiConfig_t'(value[7:0]));
	endtask

	task automatic runTransfer(input int i);
		testRow_t row;
		logic ok;
		logic [31:0] value;
		row = rows[i];
		busWrite(row.id, CONFIG_ADDRESS, 32'(row.cfg));
		monitorPol = row.cfg.spiMode[1];
		monitorPhase = row.cfg.spiMode[0];
		sampledBits.delete();
		busWrite(row.id, DATA_ADDRESS, 32'(row.data));
		waitBusy(names[i], 1'b1, ok);
		if (ok) begin
			// Inside the setup phase, word already loaded
			@(posedge clk);
			#2;
			checkPins(names[i], expectedPins(row.cfg, row.data, 1'b1), spi);
		end
		if (row.kind == DROP_ROW) begin
			busWrite(row.id, DATA_ADDRESS, 32'(~row.data));
		end
		waitBusy(names[i], 1'b0, ok);
		if (sampledBits.size() != WIDTH) begin
			$display("%s: monitor saw %0d sample edges instead of %0d", names[i],
				sampledBits.size(), WIDTH);
			testErrors++;
		end
		checkWord(names[i], row.data, wordFromBits(row.cfg.msbFirst));
		checkPins(names[i], expectedPins(row.cfg, row.data, 1'b0), spi);
		busRead(DUT_ID, DATA_ADDRESS, value);
		checkWord(names[i], row.expected[WIDTH-1:0], value[WIDTH-1:0]);
		if (busy !== 1'b0) begin
			$display("%s: a new transfer started after the read-back", names[i]);
			testErrors++;
		end
	endtask

	task automatic checkReset();
		logic [31:0] value;
		busRead(DUT_ID, CONFIG_ADDRESS, value);
		checkConfig("reset", spiConfig_t'(CONFIG_DEFAULT), spiConfig_t'(value[7:0]));
		checkPins("reset", expectedPins(spiConfig_t'(CONFIG_DEFAULT), '0, 1'b0), spi);
		if (busy !== 1'b0) begin
			$display("reset: busy is not low after reset");
			testErrors++;
		end
	endtask

	task automatic reportTest(input string name);
		if (testErrors == 0) begin
			passedTests++;
			$display("%s: ok", name);
		end else begin
			failedTests++;
			$display("%s: %0d errors", name, testErrors);
		end
	endtask

	initial begin
		rst = 1'b1;
		request = '0;
		lcgState = 32'd57;
		monitorPol = 1'b0;
		monitorPhase = 1'b0;
		passedTests = 0;
		failedTests = 0;
		buildTable();
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		testErrors = 0;
		checkReset();
		reportTest("reset");
		for (int i = 0; i < NUM_ROWS; i++) begin
			testErrors = 0;
			if (rows[i].kind == CONFIG_ROW) begin
				runConfig(i);
			end else begin
				runTransfer(i);
			end
			reportTest(names[i]);
		end
		$display("%0d tests, %0d passed, %0d failed", passedTests + failedTests, passedTests,
			failedTests);
		if (failedTests == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* project.f */
hw/spiPkg.sv
hw/peripheralRegister.sv
hw/busInterface.sv
hw/shiftRegister.sv
hw/spiController.sv
hw/spiDevice.sv
test/spiDevice_sva.sv
test/spiDeviceTb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f project.f --top-module spiDeviceTb -o simv || exit 1
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1
